// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_line_mem
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/bank_store.sv
`timescale 1ns/1ns

module bank_store (
	input  logic                       clk_50m,
	input  logic                       sys_rst_n,
	input  logic                       wr_en,
	input  logic                       rd_en,
	input  line_xfer_pkg::bank_addr_t  word_addr,
	input  line_xfer_pkg::word_t       wr_word,
	output line_xfer_pkg::word_t       rd_word,
	output logic                       rd_valid
);

	line_xfer_pkg::word_t mem [2**$bits(line_xfer_pkg::bank_addr_t)];

	// Unwritten lines read back as zero
	initial begin
		for (int i = 0; i < 2**$bits(line_xfer_pkg::bank_addr_t); i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk_50m) begin
		if (wr_en)
			mem[word_addr] <= wr_word;
		if (rd_en)
			rd_word <= mem[word_addr];	// Registered read, one cycle
	end

	always_ff @(posedge clk_50m or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_en;
	end

	a_no_rw_collision: assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		!(wr_en && rd_en));

endmodule : bank_store

// File: rtl/line_assembler.sv
`timescale 1ns/1ns

module line_assembler (
	input  logic                                                clk_50m,
	input  logic                                                sys_rst_n,
	input  logic                                                rd_start,
	input  line_xfer_pkg::word_t [sdram_geom_pkg::BANKS-1:0]    rd_word,
	input  logic [sdram_geom_pkg::BANKS-1:0]                    rd_valid,
	output line_xfer_pkg::line_t                                line_out,
	output logic                                                line_ready
);

	line_xfer_pkg::widx_t widx;	// Slot for the next returning word
	line_xfer_pkg::word_t sel_word;
	logic                 any_valid;

	// Only one bank answers per cycle, so OR of the gated words picks it
	always_comb begin
		sel_word = '0;
		for (int b = 0; b < sdram_geom_pkg::BANKS; b++) begin
			if (rd_valid[b])
				sel_word = sel_word | rd_word[b];
		end
	end

	assign any_valid = |rd_valid;

	always_ff @(posedge clk_50m) begin
		if (any_valid)
			line_out[widx*sdram_geom_pkg::WORD_W +: sdram_geom_pkg::WORD_W] <= sel_word;
	end

	always_ff @(posedge clk_50m or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			widx       <= '0;
			line_ready <= 1'b0;
		end else begin
			line_ready <= any_valid &&
				(widx == line_xfer_pkg::widx_t'(sdram_geom_pkg::LINE_WORDS - 1));
			if (rd_start)
				widx <= '0;
			else if (any_valid)
				widx <= widx + 1'b1;	// Wraps to 0 after the eighth word
		end
	end

	a_one_bank_returns: assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		$onehot0(rd_valid));

endmodule : line_assembler

// File: rtl/line_mem_top.sv
`timescale 1ns/1ns

module line_mem_top (
	input  logic                       clk_50m,
	input  logic                       sys_rst_n,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  line_xfer_pkg::line_addr_t  wb_adr,
	input  line_xfer_pkg::line_t       wb_dat_i,
	output logic                       wb_ack,
	output line_xfer_pkg::line_t       wb_dat_o,
	output logic                       refresh_busy
);

	logic [sdram_geom_pkg::BANKS-1:0]                  bank_wr_en;
	logic [sdram_geom_pkg::BANKS-1:0]                  bank_rd_en;
	line_xfer_pkg::bank_addr_t                         word_addr;
	line_xfer_pkg::word_t                              wr_word;
	logic                                              rd_start;
	logic                                              line_ready;
	line_xfer_pkg::word_t [sdram_geom_pkg::BANKS-1:0]  rd_word;	// One word per bank
	logic [sdram_geom_pkg::BANKS-1:0]                  rd_valid;

	line_port u_line_port (
		.clk_50m      (clk_50m),
		.sys_rst_n    (sys_rst_n),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_i     (wb_dat_i),
		.wb_ack       (wb_ack),
		.refresh_busy (refresh_busy),
		.bank_wr_en   (bank_wr_en),
		.bank_rd_en   (bank_rd_en),
		.word_addr    (word_addr),
		.wr_word      (wr_word),
		.rd_start     (rd_start),
		.line_ready   (line_ready)
	);

	for (genvar b = 0; b < sdram_geom_pkg::BANKS; b++) begin : gen_bank
		bank_store u_bank_store (
			.clk_50m   (clk_50m),
			.sys_rst_n (sys_rst_n),
			.wr_en     (bank_wr_en[b]),
			.rd_en     (bank_rd_en[b]),
			.word_addr (word_addr),	// Shared, enables pick the bank
			.wr_word   (wr_word),
			.rd_word   (rd_word[b]),
			.rd_valid  (rd_valid[b])
		);
	end

	line_assembler u_line_assembler (
		.clk_50m    (clk_50m),
		.sys_rst_n  (sys_rst_n),
		.rd_start   (rd_start),
		.rd_word    (rd_word),
		.rd_valid   (rd_valid),
		.line_out   (wb_dat_o),
		.line_ready (line_ready)
	);

endmodule : line_mem_top

// File: rtl/line_port.sv
`timescale 1ns/1ns

module line_port (
	input  logic                              clk_50m,
	input  logic                              sys_rst_n,
	input  logic                              wb_cyc,
	input  logic                              wb_stb,
	input  logic                              wb_we,
	input  line_xfer_pkg::line_addr_t         wb_adr,
	input  line_xfer_pkg::line_t              wb_dat_i,
	output logic                              wb_ack,
	output logic                              refresh_busy,
	output logic [sdram_geom_pkg::BANKS-1:0]  bank_wr_en,
	output logic [sdram_geom_pkg::BANKS-1:0]  bank_rd_en,
	output line_xfer_pkg::bank_addr_t         word_addr,
	output line_xfer_pkg::word_t              wr_word,
	output logic                              rd_start,
	input  logic                              line_ready
);

	line_xfer_pkg::port_state_t state, state_nxt;
	line_xfer_pkg::widx_t       beat;	// Word index of the current beat

	// Runs past the interval while the refresh window is open
	logic [$clog2(sdram_geom_pkg::REFRESH_INTERVAL + sdram_geom_pkg::REFRESH_CYCLES)-1:0]
		refresh_cnt;

	logic                               accept;
	logic                               last_beat;
	logic                               rfs_end;
	logic [sdram_geom_pkg::BANK_W-1:0]  bank_sel;
	logic [sdram_geom_pkg::BANKS-1:0]   bank_onehot;

	assign bank_sel    = wb_adr[$bits(line_xfer_pkg::line_addr_t)-1 -: sdram_geom_pkg::BANK_W];
	assign bank_onehot = {{(sdram_geom_pkg::BANKS-1){1'b0}}, 1'b1} << bank_sel;
	assign last_beat   = (beat == line_xfer_pkg::widx_t'(sdram_geom_pkg::LINE_WORDS - 1));
	assign rfs_end     = (refresh_cnt ==
		sdram_geom_pkg::REFRESH_INTERVAL + sdram_geom_pkg::REFRESH_CYCLES - 1);

	assign refresh_busy = (refresh_cnt >=
		sdram_geom_pkg::REFRESH_INTERVAL - sdram_geom_pkg::REFRESH_GUARD);

	// Ack still high means the master has not dropped stb yet
	assign accept = (state == line_xfer_pkg::IDLE) && wb_cyc && wb_stb && !wb_ack &&
		!refresh_busy;

	// Beat outputs decode straight from state so banks see them on the next edge
	assign bank_wr_en = (state == line_xfer_pkg::WR_BEAT) ? bank_onehot : '0;
	assign bank_rd_en = (state == line_xfer_pkg::RD_BEAT) ? bank_onehot : '0;
	assign word_addr  = {wb_adr[sdram_geom_pkg::ROW_W+sdram_geom_pkg::LCOL_W-1:0], beat};
	assign wr_word    = wb_dat_i[beat*sdram_geom_pkg::WORD_W +: sdram_geom_pkg::WORD_W];
	assign rd_start   = (state == line_xfer_pkg::RD_BEAT) && (beat == '0);

	always_comb begin
		state_nxt = state;
		case (state)
			line_xfer_pkg::IDLE: begin
				if (refresh_cnt >= sdram_geom_pkg::REFRESH_INTERVAL - 1)
					state_nxt = line_xfer_pkg::RFS;	// Refresh due, port is quiet
				else if (accept)
					state_nxt = wb_we ? line_xfer_pkg::WR_BEAT : line_xfer_pkg::RD_BEAT;
			end
			line_xfer_pkg::RFS: begin
				if (rfs_end)
					state_nxt = line_xfer_pkg::IDLE;
			end
			line_xfer_pkg::WR_BEAT: begin
				if (last_beat)
					state_nxt = line_xfer_pkg::DONE;
			end
			line_xfer_pkg::RD_BEAT: begin
				if (last_beat)
					state_nxt = line_xfer_pkg::RD_WAIT;
			end
			line_xfer_pkg::RD_WAIT: begin
				if (line_ready)
					state_nxt = line_xfer_pkg::IDLE;
			end
			default: state_nxt = line_xfer_pkg::IDLE;	// DONE too
		endcase
	end

	always_ff @(posedge clk_50m or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state  <= line_xfer_pkg::IDLE;
			beat   <= '0;
			wb_ack <= 1'b0;
		end else begin
			state  <= state_nxt;
			wb_ack <= (state == line_xfer_pkg::DONE) ||
				(state == line_xfer_pkg::RD_WAIT && line_ready);
			if (accept)
				beat <= '0;
			else if (state == line_xfer_pkg::WR_BEAT || state == line_xfer_pkg::RD_BEAT)
				beat <= beat + 1'b1;
		end
	end

	always_ff @(posedge clk_50m or negedge sys_rst_n) begin
		if (!sys_rst_n)
			refresh_cnt <= '0;
		else if (state == line_xfer_pkg::RFS)
			refresh_cnt <= rfs_end ? '0 : refresh_cnt + 1'b1;
		else if (refresh_cnt != sdram_geom_pkg::REFRESH_INTERVAL)
			refresh_cnt <= refresh_cnt + 1'b1;	// Holds when due until IDLE
	end

	// One bank per beat, the same bank for the whole line, never read and write at once
	a_enables_onehot: assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		$onehot0({bank_wr_en, bank_rd_en}) &&
		(beat == '0 || $stable({bank_wr_en, bank_rd_en})));

	a_stb_held: assert property (@(posedge clk_50m) disable iff (!sys_rst_n)
		(wb_cyc && wb_stb && !wb_ack) |=> (wb_cyc && wb_stb));

endmodule : line_port

// File: rtl/line_xfer_pkg.sv
package line_xfer_pkg;

	typedef logic [sdram_geom_pkg::WORD_W-1:0] word_t;	// One data word

	// Word 0 sits in the lowest bits
	typedef logic [sdram_geom_pkg::WORD_W*sdram_geom_pkg::LINE_WORDS-1:0] line_t;

	// {bank, row, line column}
	typedef logic [sdram_geom_pkg::BANK_W+sdram_geom_pkg::ROW_W+sdram_geom_pkg::LCOL_W-1:0]
		line_addr_t;

	// {row, line column, word index}
	typedef logic [sdram_geom_pkg::ROW_W+sdram_geom_pkg::LCOL_W+sdram_geom_pkg::WIDX_W-1:0]
		bank_addr_t;

	typedef logic [sdram_geom_pkg::WIDX_W-1:0] widx_t;	// Word position in a line

	typedef enum logic [2:0] {
		IDLE,		// Waiting for a request
		RFS,		// Refresh window, nothing accepted
		WR_BEAT,	// One write word per cycle
		RD_BEAT,	// One read enable per cycle
		RD_WAIT,	// Waiting for the assembled line
		DONE		// Write finished, ack next
	} port_state_t;

endpackage : line_xfer_pkg

// File: rtl/sdram_geom_pkg.sv
package sdram_geom_pkg;

	// Data path
	localparam int WORD_W     = 16;	// One SDRAM data word
	localparam int LINE_WORDS = 8;	// Words per line

	// Address split of a line
	localparam int BANKS  = 4;	// Bank stores behind the port
	localparam int BANK_W = 2;	// Bank select bits
	localparam int ROW_W  = 4;	// Row bits
	localparam int LCOL_W = 3;	// Line column bits inside a row
	localparam int WIDX_W = 3;	// Word index inside a line

	// Refresh timing, in clk_50m cycles
	localparam int REFRESH_INTERVAL = 200;	// Refresh due after this many cycles
	localparam int REFRESH_GUARD    = 12;	// Stop taking requests this early
	localparam int REFRESH_CYCLES   = 8;	// Port blocked for this long

endpackage : sdram_geom_pkg

// File: tb.f
rtl/sdram_geom_pkg.sv
rtl/line_xfer_pkg.sv
rtl/bank_store.sv
rtl/line_assembler.sv
rtl/line_port.sv
rtl/line_mem_top.sv
verification/tb_clk_gen.sv
verification/tb_line_mem.sv

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
	output logic clk_50m,
	output logic sys_rst_n
);

	initial begin
		clk_50m = 1'b0;
		forever #10 clk_50m = ~clk_50m;	// 20 ns period
	end

	initial begin
		sys_rst_n = 1'b0;
		repeat (5) @(posedge clk_50m);
		#2 sys_rst_n = 1'b1;	// Release clear of the edge
	end

endmodule : tb_clk_gen

// File: verification/tb_line_mem.sv
`timescale 1ns/1ns

module tb_line_mem;

	localparam int N_PAIRS = 16;
	localparam int N_MIXED = 60;
	localparam int N_B2B   = 16;
	localparam int MAX_GAP = 2;
	localparam int N_XFERS = 1 + 2 * N_PAIRS + N_MIXED + N_B2B + 2;

	// Guard, the window, then a full read
	localparam int REFRESH_BOUND = sdram_geom_pkg::REFRESH_GUARD +
		sdram_geom_pkg::REFRESH_CYCLES + 11;
	localparam int LAT_LIMIT = REFRESH_BOUND + 4;
	localparam int WATCHDOG_NS = (N_XFERS * (LAT_LIMIT + MAX_GAP + 1) +
		4 * sdram_geom_pkg::REFRESH_INTERVAL + 100) * 20;

	logic                       clk_50m;
	logic                       sys_rst_n;
	logic                       wb_cyc;
	logic                       wb_stb;
	logic                       wb_we;
	line_xfer_pkg::line_addr_t  wb_adr;
	line_xfer_pkg::line_t       wb_dat_i;
	logic                       wb_ack;
	line_xfer_pkg::line_t       wb_dat_o;
	logic                       refresh_busy;

	line_xfer_pkg::line_t model [line_xfer_pkg::line_addr_t];	// Last written line per address

	integer seed = 60413;
	int     data_errs  = 0;
	int     lat_errs   = 0;
	int     proto_errs = 0;
	int     busy_errs  = 0;
	int     n_xfers    = 0;
	int     rfs_phase  = 0;	// Cycles into the current refresh period

	tb_clk_gen u_clk_gen (
		.clk_50m   (clk_50m),
		.sys_rst_n (sys_rst_n)
	);

	line_mem_top UUT (
		.clk_50m      (clk_50m),
		.sys_rst_n    (sys_rst_n),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_i     (wb_dat_i),
		.wb_ack       (wb_ack),
		.wb_dat_o     (wb_dat_o),
		.refresh_busy (refresh_busy)
	);

	function automatic line_xfer_pkg::line_t rand_line();
		line_xfer_pkg::line_t l;
		for (int i = 0; i < $bits(line_xfer_pkg::line_t) / 32; i++)
			l[i*32 +: 32] = $random(seed);
		return l;
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk_50m);
			#2;
		end
	endtask

	// Busy from the guard point until the refresh window closes, sampled mid-cycle
	always @(negedge clk_50m) begin
		if (sys_rst_n) begin
			assert (refresh_busy == (rfs_phase >=
				sdram_geom_pkg::REFRESH_INTERVAL - sdram_geom_pkg::REFRESH_GUARD)) else begin
				busy_errs++;
				$display("Error at %0t ns: refresh_busy is %b at refresh cycle %0d",
					$time, refresh_busy, rfs_phase);
			end
			rfs_phase = (rfs_phase + 1) %
				(sdram_geom_pkg::REFRESH_INTERVAL + sdram_geom_pkg::REFRESH_CYCLES);
		end
	end

	// Called 2 ns after an edge, returns 2 ns after the edge that follows the ack
	task automatic run_xfer(input logic we, input line_xfer_pkg::line_addr_t adr,
		input line_xfer_pkg::line_t wdata);
		int                   cycles;
		int                   exp_lat;
		logic                 busy_at_req;
		line_xfer_pkg::line_t exp_line;
		cycles   = 0;
		exp_lat  = we ? 10 : 11;
		exp_line = model.exists(adr) ? model[adr] : '0;	// Never written reads zero
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_i = wdata;
		busy_at_req = refresh_busy;	// Stable until the request edge
		do begin
			@(posedge clk_50m);
			#2;
			cycles++;
		end while (!wb_ack && cycles < LAT_LIMIT);
		n_xfers++;
		assert (wb_ack) else begin
			proto_errs++;
			$display("Transfer to line %h was never acknowledged", adr);
		end
		if (!busy_at_req) begin
			assert (cycles == exp_lat) else begin
				lat_errs++;
				$display("Error at %0t ns: line %h %s ack after %0d cycles, expected %0d",
					$time, adr, we ? "write" : "read", cycles, exp_lat);
			end
		end else begin
			assert (cycles <= REFRESH_BOUND) else begin
				lat_errs++;
				$display("Error at %0t ns: line %h ack after %0d cycles during refresh, bound %0d",
					$time, adr, cycles, REFRESH_BOUND);
			end
		end
		if (we)
			model[adr] = wdata;
		else
			assert (wb_dat_o === exp_line) else begin
				data_errs++;
				$display("Error at %0t ns: line %h read %h, expected %h",
					$time, adr, wb_dat_o, exp_line);
			end
		@(posedge clk_50m);
		#2;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		assert (!wb_ack) else begin
			proto_errs++;
			$display("Ack for line %h stayed high for more than one cycle", adr);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		line_xfer_pkg::line_addr_t adr;
		line_xfer_pkg::line_t      dat;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_i = '0;
		@(posedge sys_rst_n);
		@(posedge clk_50m);
		#2;
		for (int i = 0; i < 10; i++) begin	// Quiet bus after reset
			assert (!wb_ack) else begin
				proto_errs++;
				$display("Ack went high with no request pending");
			end
			idle_cycles(1);
		end
		run_xfer(1'b0, line_xfer_pkg::line_addr_t'($random(seed)), '0);	// Fresh memory
		for (int i = 0; i < N_PAIRS; i++) begin
			adr = line_xfer_pkg::line_addr_t'($random(seed));
			adr[$bits(adr)-1 -: sdram_geom_pkg::BANK_W] = sdram_geom_pkg::BANK_W'(i);
			dat = rand_line();
			run_xfer(1'b1, adr, dat);
			idle_cycles($unsigned($random(seed)) % (MAX_GAP + 1));
			run_xfer(1'b0, adr, '0);
		end
		for (int i = 0; i < N_MIXED; i++) begin
			adr = line_xfer_pkg::line_addr_t'($random(seed)) & 9'b110000011;	// 16 lines, overwrites
			run_xfer(($random(seed) & 1) == 1, adr, rand_line());
			idle_cycles($unsigned($random(seed)) % (MAX_GAP + 1));
		end
		for (int i = 0; i < N_B2B; i++)	// Next stb raised right after each ack
			run_xfer(i % 2 == 0, line_xfer_pkg::line_addr_t'(i / 2 * 37), rand_line());
		adr = line_xfer_pkg::line_addr_t'($random(seed));
		while (!refresh_busy)
			idle_cycles(1);
		run_xfer(1'b1, adr, rand_line());
		while (!refresh_busy)
			idle_cycles(1);
		run_xfer(1'b0, adr, '0);
		$display("Summary: %0d transfers, %0d data errors, %0d latency errors, %0d %s, %0d %s",
			n_xfers, data_errs, lat_errs, proto_errs, "protocol errors", busy_errs,
			"refresh_busy errors");
		if (data_errs + lat_errs + proto_errs + busy_errs == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule : tb_line_mem
